/* fft_accel.f */
+incdir+logic
+incdir+sim
logic/fft_accel_pkg.sv
logic/sample_ram.sv
logic/ram_arbiter.sv
logic/fft_sequencer.sv
logic/butterfly_unit.sv
logic/fft_accel_top.sv
sim/fft_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the FFT accelerator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
        --top-module fft_accel_tb -f fft_accel.f \
        --Mdir obj_dir -o fft_accel_sim
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/fft_accel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -eq 0 ] && grep -q "^TESTBENCH PASSED$" "$LOG"; then
        echo "Simulation passed"
        exit 0
fi
echo "Simulation failed"
exit 1

/* sim/fft_accel_ref.svh */
// Behavioral model of the 8-point radix-2 DIT transform
// Include inside the testbench module, after the package import

`ifndef FFT_ACCEL_REF_SVH
`define FFT_ACCEL_REF_SVH

typedef sample_t sample_vec_t [`FFT_POINTS];

// Load index to RAM index
function automatic int bit_reverse(input int idx);
        int rev;
        rev = 0;
        for (int i = 0; i < `FFT_LOG2_POINTS; i++) begin
                rev = (rev << 1) | ((idx >> i) & 1);
        end
        return rev;
endfunction

// Input in load order, output in bin order
function automatic sample_vec_t fft_ref(input sample_vec_t din);
        sample_vec_t x;
        int          tw_re [4];
        int          tw_im [4];
        int          h;
        int          a;
        int          b;
        int          k;
        int          p_re;
        int          p_im;
        tw_re = '{256, 181, 0, -181};
        tw_im = '{0, -181, -256, -181};
        for (int i = 0; i < `FFT_POINTS; i++) begin
                x[bit_reverse(i)] = din[i];
        end
        for (int s = 0; s < `FFT_LOG2_POINTS; s++) begin
                h = 1 << s;
                for (int g = 0; g < `FFT_POINTS; g += 2 * h) begin
                        for (int j = 0; j < h; j++) begin
                                a = g + j;
                                b = a + h;
                                k = j * `FFT_POINTS / (2 * h);
                                p_re = (tw_re[k] * int'(x[b].re) - tw_im[k] * int'(x[b].im))
                                       >>> `TWIDDLE_FRAC_BITS;
                                p_im = (tw_re[k] * int'(x[b].im) + tw_im[k] * int'(x[b].re))
                                       >>> `TWIDDLE_FRAC_BITS;
                                // Bottom first, it still needs the old top value
                                x[b].re = `SAMPLE_WIDTH'(int'(x[a].re) - p_re);
                                x[b].im = `SAMPLE_WIDTH'(int'(x[a].im) - p_im);
                                x[a].re = `SAMPLE_WIDTH'(int'(x[a].re) + p_re);
                                x[a].im = `SAMPLE_WIDTH'(int'(x[a].im) + p_im);
                        end
                end
        end
        return x;
endfunction

`endif

/* sim/fft_accel_tb.sv */
// Testbench for the FFT accelerator top level
// Loads samples through both ports, runs transforms, reads bins back

`timescale 1ns/1ps
`include "fft_accel_config.svh"

module fft_accel_tb;
        import fft_accel_pkg::*;
        `include "fft_accel_ref.svh"

        localparam int SW            = `SAMPLE_WIDTH;
        localparam int DONE_TIMEOUT  = 200;
        localparam int DRAIN_TIMEOUT = 10;

        logic        clk;
        logic        rst_n;
        core_wr_t    core_wr;
        host_req_t   host_req;
        logic        start;
        sample_t     host_rd_data;
        logic        host_rd_valid;
        logic        busy;
        logic        done;

        integer      seed;
        sample_vec_t loaded;
        sample_t     exp_q [$];
        int          done_count;
        int          fft_runs;

        fft_accel_top DUT (
                .clk             (clk),
                .rst_n_i         (rst_n),
                .core_wr_i       (core_wr),
                .host_req_i      (host_req),
                .start_i         (start),
                .host_rd_data_o  (host_rd_data),
                .host_rd_valid_o (host_rd_valid),
                .busy_o          (busy),
                .done_o          (done)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        //////////////////////////////////////////////////////////////////////
        // Checks
        //////////////////////////////////////////////////////////////////////

        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("TESTBENCH FAILED");
                $fatal(1, "%s", reason);
        endtask

        task automatic check_sample(input string name, input sample_t got,
                                    input sample_t expected);
                if (got !== expected) begin
                        $display("[FAIL] %s: got %h, expected %h", name, got, expected);
                        abort_run("stopping at the first mismatch");
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic expected);
                if (got !== expected) begin
                        $display("[FAIL] %s: got %h, expected %h", name, got, expected);
                        abort_run("stopping at the first mismatch");
                end
        endtask

        // Every returned read is matched against the oldest expected value
        always @(negedge clk) begin
                if (rst_n && host_rd_valid) begin
                        if (exp_q.size() == 0) begin
                                abort_run("host read data came back with no read pending");
                        end else begin
                                check_sample("host_rd_data_o", host_rd_data, exp_q.pop_front());
                        end
                end
        end

        always @(negedge clk) begin
                if (rst_n && done) begin
                        done_count++;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Stimulus tasks
        //////////////////////////////////////////////////////////////////////

        function automatic sample_t random_sample();
                sample_t s;
                s.re = SW'($random(seed) % 512);
                s.im = SW'($random(seed) % 512);
                return s;
        endfunction

        task automatic core_write(input int idx, input sample_t data);
                @(posedge clk);
                #1;
                core_wr = '{en: 1'b1, addr: sample_addr_t'(idx), data: data};
                @(posedge clk);
                #1;
                core_wr.en = 1'b0;
                loaded[idx] = data;
        endtask

        task automatic host_write(input int idx, input sample_t data);
                @(posedge clk);
                #1;
                host_req = '{en: 1'b1, we: 1'b1, addr: sample_addr_t'(idx), data: data};
                @(posedge clk);
                #1;
                host_req.en = 1'b0;
                loaded[idx] = data;
        endtask

        // Data itself is checked by the compare process
        task automatic host_read(input int idx, input sample_t expected);
                @(posedge clk);
                #1;
                host_req = '{en: 1'b0, we: 1'b0, addr: sample_addr_t'(idx), data: '0};
                host_req.en = 1'b1;
                exp_q.push_back(expected);
                @(posedge clk);
                #1;
                host_req.en = 1'b0;
                check_bit("host_rd_valid_o", host_rd_valid, 1'b1);
        endtask

        task automatic load_random(input logic mixed);
                sample_t s;
                for (int i = 0; i < `FFT_POINTS; i++) begin
                        s = random_sample();
                        if (mixed && ($random(seed) & 1)) begin
                                core_write(i, s);
                        end else begin
                                host_write(i, s);
                        end
                end
        endtask

        task automatic start_fft();
                @(posedge clk);
                #1;
                start = 1'b1;
                @(posedge clk);
                #1;
                start = 1'b0;
                fft_runs++;
                check_bit("busy_o", busy, 1'b1);
        endtask

        task automatic wait_done();
                int cycles;
                cycles = 0;
                while (done !== 1'b1) begin
                        if (cycles == DONE_TIMEOUT) begin
                                abort_run("transform did not finish, done_o never pulsed");
                        end else begin
                                @(posedge clk);
                                #1;
                                cycles++;
                        end
                end
                check_bit("busy_o", busy, 1'b0);
        endtask

        task automatic check_bins();
                sample_vec_t expected;
                expected = fft_ref(loaded);
                for (int k = 0; k < `FFT_POINTS; k++) begin
                        host_read(k, expected[k]);
                end
        endtask

        task automatic drain_reads();
                int cycles;
                cycles = 0;
                while (exp_q.size() != 0) begin
                        if (cycles == DRAIN_TIMEOUT) begin
                                abort_run("pending host reads never returned data");
                        end else begin
                                @(negedge clk);
                                cycles++;
                        end
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Test sequence
        //////////////////////////////////////////////////////////////////////

        initial begin
                sample_t     impulse;
                sample_t     core_data;
                sample_t     host_data;
                sample_vec_t expected;
                seed       = 81;
                done_count = 0;
                fft_runs   = 0;
                rst_n      = 1'b0;
                core_wr    = '0;
                host_req   = '0;
                start      = 1'b0;
                repeat (5) @(posedge clk);
                #1;
                rst_n = 1'b1;
                check_bit("busy_o", busy, 1'b0);
                check_bit("done_o", done, 1'b0);
                check_bit("host_rd_valid_o", host_rd_valid, 1'b0);

                // Host loads land bit-reversed
                load_random(1'b0);
                for (int i = 0; i < `FFT_POINTS; i++) begin
                        host_read(i, loaded[bit_reverse(i)]);
                end

                // Impulse at index 0 gives a flat spectrum
                impulse = '{re: SW'(100), im: SW'(-37)};
                core_write(0, impulse);
                for (int i = 1; i < `FFT_POINTS; i++) begin
                        core_write(i, '0);
                end
                expected = fft_ref(loaded);
                for (int k = 0; k < `FFT_POINTS; k++) begin
                        check_sample("fft_ref bin", expected[k], impulse);
                end
                start_fft();
                wait_done();
                check_bins();

                repeat (3) begin
                        load_random(1'b1);
                        start_fft();
                        wait_done();
                        check_bins();
                end

                // Same-cycle core and host write, core wins
                core_data = random_sample();
                host_data = random_sample();
                @(posedge clk);
                #1;
                core_wr  = '{en: 1'b1, addr: sample_addr_t'(3), data: core_data};
                host_req = '{en: 1'b1, we: 1'b1, addr: sample_addr_t'(3), data: host_data};
                @(posedge clk);
                #1;
                core_wr.en  = 1'b0;
                host_req.en = 1'b0;
                loaded[3] = core_data;
                host_read(bit_reverse(3), loaded[3]);

                // Requests during a transform are dropped
                load_random(1'b1);
                start_fft();
                core_wr  = '{en: 1'b1, addr: sample_addr_t'(2), data: random_sample()};
                host_req = '{en: 1'b1, we: 1'b1, addr: sample_addr_t'(5), data: random_sample()};
                start    = 1'b1;
                @(posedge clk);
                #1;
                core_wr.en  = 1'b0;
                host_req.en = 1'b0;
                start       = 1'b0;
                check_bit("busy_o", busy, 1'b1);
                host_req = '{en: 1'b1, we: 1'b0, addr: sample_addr_t'(0), data: '0};
                @(posedge clk);
                #1;
                host_req.en = 1'b0;
                check_bit("host_rd_valid_o", host_rd_valid, 1'b0);
                wait_done();
                check_bins();
                drain_reads();

                // Long enough for a second transform to show up
                repeat (80) @(posedge clk);
                if (done_count != fft_runs) begin
                        abort_run($sformatf("saw %0d done pulses for %0d transforms",
                                            done_count, fft_runs));
                end else begin
                        $display("TESTBENCH PASSED");
                        $finish;
                end
        end

endmodule

/* logic/fft_accel_top.sv */
// Top level of the FFT accelerator
// Core port, host port and the FFT engine share one sample RAM

`timescale 1ns/1ps

module fft_accel_top (
        input  logic                      clk,
        input  logic                      rst_n_i,
        input  fft_accel_pkg::core_wr_t   core_wr_i,
        input  fft_accel_pkg::host_req_t  host_req_i,
        input  logic                      start_i,
        output fft_accel_pkg::sample_t    host_rd_data_o,
        output logic                      host_rd_valid_o,
        output logic                      busy_o,
        output logic                      done_o
);
        import fft_accel_pkg::*;

        ram_wr_t      eng_wr;
        ram_wr_t      ram_wr;
        sample_addr_t eng_raddr;
        sample_addr_t ram_raddr;
        sample_t      ram_rdata;
        sample_t      opa;
        sample_t      opb;
        sample_t      bfly_top;
        sample_t      bfly_bot;
        twiddle_idx_t tw_idx;
        logic         busy;

        assign host_rd_data_o = ram_rdata;
        assign busy_o         = busy;

        //////////////////////////////////////////////////////////////////////
        // Shared RAM
        //////////////////////////////////////////////////////////////////////

        ram_arbiter u_arbiter (
                .clk             (clk),
                .rst_n_i         (rst_n_i),
                .core_wr_i       (core_wr_i),
                .host_req_i      (host_req_i),
                .busy_i          (busy),
                .eng_wr_i        (eng_wr),
                .eng_raddr_i     (eng_raddr),
                .ram_wr_o        (ram_wr),
                .ram_raddr_o     (ram_raddr),
                .host_rd_valid_o (host_rd_valid_o)
        );

        sample_ram u_ram (
                .clk     (clk),
                .wr_i    (ram_wr),
                .raddr_i (ram_raddr),
                .rdata_o (ram_rdata)
        );

        //////////////////////////////////////////////////////////////////////
        // FFT engine
        //////////////////////////////////////////////////////////////////////

        fft_sequencer u_sequencer (
                .clk        (clk),
                .rst_n_i    (rst_n_i),
                .start_i    (start_i),
                .rdata_i    (ram_rdata),
                .bfly_top_i (bfly_top),
                .bfly_bot_i (bfly_bot),
                .raddr_o    (eng_raddr),
                .wr_o       (eng_wr),
                .opa_o      (opa),
                .opb_o      (opb),
                .tw_idx_o   (tw_idx),
                .busy_o     (busy),
                .done_o     (done_o)
        );

        butterfly_unit u_butterfly (
                .clk      (clk),
                .opa_i    (opa),
                .opb_i    (opb),
                .tw_idx_i (tw_idx),
                .top_o    (bfly_top),
                .bot_o    (bfly_bot)
        );

endmodule

/* logic/butterfly_unit.sv */
// Radix-2 DIT butterfly with the 8-point Q8 twiddle table
// Outputs a+wb and a-wb, registered, wrapped to sample width

`timescale 1ns/1ps
`include "fft_accel_config.svh"

module butterfly_unit (
        input  logic                         clk,
        input  fft_accel_pkg::sample_t       opa_i,
        input  fft_accel_pkg::sample_t       opb_i,
        input  fft_accel_pkg::twiddle_idx_t  tw_idx_i,
        output fft_accel_pkg::sample_t       top_o,
        output fft_accel_pkg::sample_t       bot_o
);
        localparam int SW     = `SAMPLE_WIDTH;
        localparam int TW     = `TWIDDLE_WIDTH;
        localparam int TW_ONE = 1 << `TWIDDLE_FRAC_BITS;
        // cos(pi/4) in Q8
        localparam int TW_R2  = 181;

        logic signed [TW-1:0] tw_re;
        logic signed [TW-1:0] tw_im;
        logic signed [SW+TW:0] prod_re;
        logic signed [SW+TW:0] prod_im;
        logic signed [SW+TW:0] shift_re;
        logic signed [SW+TW:0] shift_im;
        logic signed [SW-1:0] p_re;
        logic signed [SW-1:0] p_im;

        // e^(-j*2*pi*k/8)
        always_comb begin
                case (tw_idx_i)
                        2'd0: begin
                                tw_re = TW'(TW_ONE);
                                tw_im = TW'(0);
                        end
                        2'd1: begin
                                tw_re = TW'(TW_R2);
                                tw_im = TW'(-TW_R2);
                        end
                        2'd2: begin
                                tw_re = TW'(0);
                                tw_im = TW'(-TW_ONE);
                        end
                        default: begin
                                tw_re = TW'(-TW_R2);
                                tw_im = TW'(-TW_R2);
                        end
                endcase
        end

        // Full-width sums before the Q8 shift
        assign prod_re  = (tw_re * opb_i.re) - (tw_im * opb_i.im);
        assign prod_im  = (tw_re * opb_i.im) + (tw_im * opb_i.re);
        assign shift_re = prod_re >>> `TWIDDLE_FRAC_BITS;
        assign shift_im = prod_im >>> `TWIDDLE_FRAC_BITS;
        assign p_re     = shift_re[SW-1:0];
        assign p_im     = shift_im[SW-1:0];

        always_ff @(posedge clk) begin
                top_o.re <= opa_i.re + p_re;
                top_o.im <= opa_i.im + p_im;
                bot_o.re <= opa_i.re - p_re;
                bot_o.im <= opa_i.im - p_im;
        end

endmodule

/* logic/fft_sequencer.sv */
// Control for the in-place radix-2 DIT transform
// Walks stage, group and offset; five states per butterfly

`timescale 1ns/1ps
`include "fft_accel_config.svh"

module fft_sequencer (
        input  logic                         clk,
        input  logic                         rst_n_i,
        input  logic                         start_i,
        input  fft_accel_pkg::sample_t       rdata_i,
        input  fft_accel_pkg::sample_t       bfly_top_i,
        input  fft_accel_pkg::sample_t       bfly_bot_i,
        output fft_accel_pkg::sample_addr_t  raddr_o,
        output fft_accel_pkg::ram_wr_t       wr_o,
        output fft_accel_pkg::sample_t       opa_o,
        output fft_accel_pkg::sample_t       opb_o,
        output fft_accel_pkg::twiddle_idx_t  tw_idx_o,
        output logic                         busy_o,
        output logic                         done_o
);
        import fft_accel_pkg::*;

        localparam int STAGE_W = $clog2(`FFT_LOG2_POINTS);
        localparam int ADDR_W  = `FFT_LOG2_POINTS;

        seq_state_e         state_q;
        seq_state_e         state_d;
        logic [STAGE_W-1:0] stage_q;
        sample_addr_t       group_q;
        sample_addr_t       offset_q;
        sample_addr_t       half_w;
        sample_addr_t       a_addr_w;
        sample_addr_t       b_addr_w;
        sample_addr_t       tw_full_w;
        logic [ADDR_W:0]    next_group_w;
        logic               last_offset_w;
        logic               last_group_w;
        logic               last_stage_w;
        sample_t            a_q;
        sample_t            b_q;
        logic               busy_q;
        logic               done_q;

        //////////////////////////////////////////////////////////////////////
        // Butterfly addressing
        //////////////////////////////////////////////////////////////////////

        assign half_w        = ADDR_W'(1) << stage_q;
        assign a_addr_w      = group_q + offset_q;
        assign b_addr_w      = a_addr_w + half_w;
        assign next_group_w  = {1'b0, group_q} + {half_w, 1'b0};
        assign last_offset_w = offset_q == half_w - 1'b1;
        assign last_group_w  = next_group_w == (ADDR_W+1)'(`FFT_POINTS);
        assign last_stage_w  = stage_q == STAGE_W'(`FFT_LOG2_POINTS - 1);

        // j * N / (2h)
        assign tw_full_w = offset_q << (STAGE_W'(`FFT_LOG2_POINTS - 1) - stage_q);
        assign tw_idx_o  = twiddle_idx_t'(tw_full_w);

        // Counters wrap back to zero after the last butterfly
        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        stage_q  <= '0;
                        group_q  <= '0;
                        offset_q <= '0;
                end else if (state_q == SEQ_WRITE_B) begin
                        if (!last_offset_w) begin
                                offset_q <= offset_q + 1'b1;
                        end else begin
                                offset_q <= '0;
                                if (!last_group_w) begin
                                        group_q <= next_group_w[ADDR_W-1:0];
                                end else begin
                                        group_q <= '0;
                                        stage_q <= last_stage_w ? '0 : stage_q + 1'b1;
                                end
                        end
                end
        end

        //////////////////////////////////////////////////////////////////////
        // State machine
        //////////////////////////////////////////////////////////////////////

        always_comb begin
                state_d = state_q;
                case (state_q)
                        SEQ_IDLE, SEQ_DONE: state_d = start_i ? SEQ_READ_A : SEQ_IDLE;
                        SEQ_READ_A:         state_d = SEQ_READ_B;
                        SEQ_READ_B:         state_d = SEQ_CALC;
                        SEQ_CALC:           state_d = SEQ_WRITE_A;
                        SEQ_WRITE_A:        state_d = SEQ_WRITE_B;
                        SEQ_WRITE_B: begin
                                if (last_offset_w && last_group_w && last_stage_w) begin
                                        state_d = SEQ_DONE;
                                end else begin
                                        state_d = SEQ_READ_A;
                                end
                        end
                        default:            state_d = SEQ_IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        state_q <= SEQ_IDLE;
                        busy_q  <= 1'b0;
                        done_q  <= 1'b0;
                end else begin
                        state_q <= state_d;
                        busy_q  <= state_d inside {SEQ_READ_A, SEQ_READ_B, SEQ_CALC,
                                                   SEQ_WRITE_A, SEQ_WRITE_B};
                        // Pulse after the last write of the last stage
                        done_q  <= state_q == SEQ_WRITE_B && last_offset_w &&
                                   last_group_w && last_stage_w;
                end
        end

        assign busy_o = busy_q;
        assign done_o = done_q;

        // A arrives in READ_B, B in CALC
        always_ff @(posedge clk) begin
                if (state_q == SEQ_READ_B) begin
                        a_q <= rdata_i;
                end
                if (state_q == SEQ_CALC) begin
                        b_q <= rdata_i;
                end
        end

        // B is forwarded in CALC and held after, so results stay put
        assign opa_o   = a_q;
        assign opb_o   = (state_q == SEQ_CALC) ? rdata_i : b_q;
        assign raddr_o = (state_q == SEQ_READ_B) ? b_addr_w : a_addr_w;

        always_comb begin
                wr_o.we   = state_q inside {SEQ_WRITE_A, SEQ_WRITE_B};
                wr_o.addr = (state_q == SEQ_WRITE_B) ? b_addr_w : a_addr_w;
                wr_o.data = (state_q == SEQ_WRITE_B) ? bfly_bot_i : bfly_top_i;
        end

        a_done_in_done_state : assert property (
                @(posedge clk) disable iff (!rst_n_i)
                done_o |-> state_q == SEQ_DONE && !busy_o
        ) else $error("done pulse outside the DONE state");

endmodule

/* logic/ram_arbiter.sv */
// Picks the owner of the sample RAM each cycle
// Engine while busy, otherwise core writes, then host accesses

`timescale 1ns/1ps

module ram_arbiter (
        input  logic                         clk,
        input  logic                         rst_n_i,
        input  fft_accel_pkg::core_wr_t      core_wr_i,
        input  fft_accel_pkg::host_req_t     host_req_i,
        input  logic                         busy_i,
        input  fft_accel_pkg::ram_wr_t       eng_wr_i,
        input  fft_accel_pkg::sample_addr_t  eng_raddr_i,
        output fft_accel_pkg::ram_wr_t       ram_wr_o,
        output fft_accel_pkg::sample_addr_t  ram_raddr_o,
        output logic                         host_rd_valid_o
);
        import fft_accel_pkg::*;

        logic host_wr_w;
        logic host_rd_w;

        // Loads land bit-reversed so the DIT engine works in place
        function automatic sample_addr_t bit_rev(input sample_addr_t idx);
                sample_addr_t rev;
                for (int i = 0; i < $bits(sample_addr_t); i++) begin
                        rev[i] = idx[$bits(sample_addr_t)-1-i];
                end
                return rev;
        endfunction

        assign host_wr_w = host_req_i.en && host_req_i.we;
        assign host_rd_w = host_req_i.en && !host_req_i.we;

        always_comb begin
                ram_wr_o    = eng_wr_i;
                ram_raddr_o = eng_raddr_i;
                if (!busy_i) begin
                        // Host reads use the natural index
                        ram_raddr_o = host_req_i.addr;
                        if (core_wr_i.en) begin
                                ram_wr_o.we   = 1'b1;
                                ram_wr_o.addr = bit_rev(core_wr_i.addr);
                                ram_wr_o.data = core_wr_i.data;
                        end else begin
                                ram_wr_o.we   = host_wr_w;
                                ram_wr_o.addr = bit_rev(host_req_i.addr);
                                ram_wr_o.data = host_req_i.data;
                        end
                end
        end

        // Lines up with the registered RAM read
        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        host_rd_valid_o <= 1'b0;
                end else begin
                        host_rd_valid_o <= host_rd_w && !busy_i;
                end
        end

        a_no_load_while_busy : assert property (
                @(posedge clk) disable iff (!rst_n_i)
                busy_i && ram_wr_o.we |-> eng_wr_i.we && ram_wr_o.addr == eng_wr_i.addr
        ) else $error("core or host write reached the RAM during a transform");

        a_engine_only_busy : assert property (
                @(posedge clk) disable iff (!rst_n_i)
                eng_wr_i.we |-> busy_i
        ) else $error("engine write outside of a transform");

endmodule

/* logic/sample_ram.sv */
// Complex sample memory shared by loaders, host readback and the engine
// One write port, one read port with registered data

`timescale 1ns/1ps
`include "fft_accel_config.svh"

module sample_ram (
        input  logic                         clk,
        input  fft_accel_pkg::ram_wr_t       wr_i,
        input  fft_accel_pkg::sample_addr_t  raddr_i,
        output fft_accel_pkg::sample_t       rdata_o
);
        import fft_accel_pkg::*;

        sample_t mem [`FFT_POINTS];

        always_ff @(posedge clk) begin
                if (wr_i.we) begin
                        mem[wr_i.addr] <= wr_i.data;
                end
        end

        // Read data one cycle after the address
        always_ff @(posedge clk) begin
                rdata_o <= mem[raddr_i];
        end

        a_wr_addr_known : assert property (
                @(posedge clk) wr_i.we |-> !$isunknown(wr_i.addr)
        ) else $error("sample RAM write with unknown address");

endmodule

/* logic/fft_accel_pkg.sv */
// Shared types of the FFT accelerator
// Samples, RAM addresses, requester structs and sequencer states

`include "fft_accel_config.svh"

package fft_accel_pkg;

        // Complex sample, real part in the upper half
        typedef struct packed {
                logic signed [`SAMPLE_WIDTH-1:0] re;
                logic signed [`SAMPLE_WIDTH-1:0] im;
        } sample_t;

        typedef logic [`FFT_LOG2_POINTS-1:0] sample_addr_t;
        typedef logic [`FFT_LOG2_POINTS-2:0] twiddle_idx_t;

        // Core accelerator write strobe
        typedef struct packed {
                logic         en;
                sample_addr_t addr;
                sample_t      data;
        } core_wr_t;

        // Host access, read when we is low
        typedef struct packed {
                logic         en;
                logic         we;
                sample_addr_t addr;
                sample_t      data;
        } host_req_t;

        typedef struct packed {
                logic         we;
                sample_addr_t addr;
                sample_t      data;
        } ram_wr_t;

        typedef enum logic [2:0] {
                SEQ_IDLE,
                SEQ_READ_A,
                SEQ_READ_B,
                SEQ_CALC,
                SEQ_WRITE_A,
                SEQ_WRITE_B,
                SEQ_DONE
        } seq_state_e;

endpackage

/* logic/fft_accel_config.svh */
// Build constants for the 8-point FFT accelerator
// Include wherever point count or sample widths are needed

`ifndef FFT_ACCEL_CONFIG_SVH
`define FFT_ACCEL_CONFIG_SVH

// Transform size, stages first
`define FFT_LOG2_POINTS 3
`define FFT_POINTS (1 << `FFT_LOG2_POINTS)

// Real and imaginary part width
`define SAMPLE_WIDTH 16

// Twiddles in Q8, wide enough for +256 and -256
`define TWIDDLE_WIDTH 10
`define TWIDDLE_FRAC_BITS 8

`endif
